// ==== vlog.f ====
source/lane_pkg.sv
source/lane_sequencer.sv
source/vector_regfile.sv
source/lane_alu.sv
source/lane_writeback.sv
source/lane_top.sv
sim/lane_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the lane testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module lane_tb -o lane_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/lane_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "test passed"; then
  exit 0
fi
exit 1

// ==== sim/lane_tb.sv ====
//////////////////////////////
// Testbench of the vector lane
// Shadow register file and ALU reference function
// Store port read-back compare process
// Load, instruction and timing checks
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module lane_tb;
  import lane_pkg::*;

  localparam int MaxWait = 100;
  localparam int NrOps   = 10;

  logic      clk_i;
  logic      rst_ni;
  pe_req_t   pe_req_i;
  logic      pe_req_valid_i;
  logic      pe_req_ready_o;
  logic      alu_vinsn_done_o;
  logic      ldu_req_i;
  vrf_wr_t   ldu_wr_i;
  logic      ldu_gnt_o;
  logic      stu_req_i;
  vrf_addr_t stu_addr_i;
  elem_t     stu_rdata_o;
  logic      stu_valid_o;

  elem_t     shadow [NrVRegs][ElemsPerVReg];
  elem_t     exp_q [$];
  vrf_addr_t exp_addr_q [$];
  elem_t     exp_val;
  vrf_addr_t exp_addr;
  int        seed;
  int        data_errs;
  int        ctrl_errs;
  int        reads;
  int        instrs;
  bit        timed_out;

  lane_top lane_top_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .pe_req_i         (pe_req_i),
    .pe_req_valid_i   (pe_req_valid_i),
    .pe_req_ready_o   (pe_req_ready_o),
    .alu_vinsn_done_o (alu_vinsn_done_o),
    .ldu_req_i        (ldu_req_i),
    .ldu_wr_i         (ldu_wr_i),
    .ldu_gnt_o        (ldu_gnt_o),
    .stu_req_i        (stu_req_i),
    .stu_addr_i       (stu_addr_i),
    .stu_rdata_o      (stu_rdata_o),
    .stu_valid_o      (stu_valid_o)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // a is the vs2 element, b the vs1 element or the scalar
  function automatic elem_t alu_ref(alu_op_e op, elem_t a, elem_t b);
    logic [4:0]              sh;
    logic [2*ElemWidth-1:0]  ext;
    elem_t                   res;
    sh  = b[4:0];
    ext = {{ElemWidth{a[ElemWidth-1]}}, a} >> sh;
    case (op)
      VADD:    res = a + b;
      VSUB:    res = a - b;
      VAND:    res = a & b;
      VOR:     res = a | b;
      VXOR:    res = a ^ b;
      VSLL:    res = a << sh;
      VSRL:    res = a >> sh;
      VSRA:    res = ext[ElemWidth-1:0];
      // Flipping the sign bit turns a signed compare into an unsigned one
      VMIN:    res = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? a : b;
      VMAX:    res = ((a ^ 32'h8000_0000) > (b ^ 32'h8000_0000)) ? a : b;
      default: res = '0;
    endcase
    return res;
  endfunction

  // Store port compare
  always @(negedge clk_i) begin
    if (stu_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("Store port returned data with no read pending at %0t", $time);
        data_errs++;
      end else begin
        exp_val  = exp_q.pop_front();
        exp_addr = exp_addr_q.pop_front();
        reads++;
        if (stu_rdata_o !== exp_val) begin
          $display("ERR %0t stu_rdata_o v%0d[%0d] expected %08h actual %08h", $time,
                   exp_addr.vreg, exp_addr.idx, exp_val, stu_rdata_o);
          data_errs++;
        end
      end
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic note_timeout(input string what);
    $display("Timeout after %0d cycles waiting for %s at %0t", MaxWait, what, $time);
    timed_out = 1'b1;
  endtask

  task automatic ctrl_err(input string sig, input int expv, input int actv);
    $display("ERR %0t %s expected %0d actual %0d", $time, sig, expv, actv);
    ctrl_errs++;
  endtask

  task automatic read_check(input vreg_t v, input eidx_t e);
    int n;
    if (timed_out) return;
    exp_q.push_back(shadow[v][e]);
    exp_addr_q.push_back('{vreg: v, idx: e});
    @(posedge clk_i);
    stu_req_i  <= 1'b1;
    stu_addr_i <= '{vreg: v, idx: e};
    @(posedge clk_i);
    stu_req_i <= 1'b0;
    n = 0;
    @(negedge clk_i);
    while (!stu_valid_o && n < MaxWait) begin
      @(negedge clk_i);
      n++;
    end
    if (!stu_valid_o) note_timeout("stu_valid_o");
  endtask

  task automatic verify_all();
    for (int v = 0; v < NrVRegs; v++) begin
      for (int e = 0; e < ElemsPerVReg; e++) begin
        read_check(vreg_t'(v), eidx_t'(e));
      end
    end
    // Let the compare process see the last strobe
    @(posedge clk_i);
  endtask

  task automatic load_write(input vreg_t v, input eidx_t e, input elem_t d);
    int n;
    if (timed_out) return;
    @(posedge clk_i);
    ldu_req_i <= 1'b1;
    ldu_wr_i  <= '{addr: '{vreg: v, idx: e}, data: d};
    n = 0;
    @(negedge clk_i);
    while (!ldu_gnt_o && n < MaxWait) begin
      @(negedge clk_i);
      n++;
    end
    if (!ldu_gnt_o) note_timeout("ldu_gnt_o");
    else shadow[v][e] = d;
    // Granted write lands on this edge
    @(posedge clk_i);
    ldu_req_i <= 1'b0;
  endtask

  function automatic pe_req_t make_req(alu_op_e op, int vl, logic use_scalar, elem_t scalar);
    pe_req_t r;
    r.op         = op;
    r.vd         = vreg_t'($random(seed));
    r.vs1        = vreg_t'($random(seed));
    r.vs2        = vreg_t'($random(seed));
    r.vl         = vl_t'(vl);
    r.use_scalar = use_scalar;
    r.scalar     = scalar;
    return r;
  endfunction

  //////////////////////////////
  // Instruction with timing checks
  //////////////////////////////

  // j counts edges after the accepting edge, sampled at the falling edge
  task automatic run_instr(input pe_req_t req, input bit with_load, input elem_t ld_data);
    int    n;
    int    j;
    int    vl;
    int    done_cnt;
    int    done_j;
    int    ready_j;
    int    ld_at;
    bit    ld_busy;
    elem_t b;
    elem_t new_vals [ElemsPerVReg];
    if (timed_out) return;
    vl = int'(req.vl);
    for (int e = 0; e < vl; e++) begin
      b = req.use_scalar ? req.scalar : shadow[req.vs1][e];
      new_vals[e] = alu_ref(req.op, shadow[req.vs2][e], b);
    end
    @(posedge clk_i);
    pe_req_i       <= req;
    pe_req_valid_i <= 1'b1;
    n = 0;
    @(negedge clk_i);
    while (!pe_req_ready_o && n < MaxWait) begin
      @(negedge clk_i);
      n++;
    end
    if (!pe_req_ready_o) begin
      note_timeout("pe_req_ready_o before issue");
      return;
    end
    @(posedge clk_i);
    pe_req_valid_i <= 1'b0;
    instrs++;
    j        = -1;
    done_cnt = 0;
    done_j   = -1;
    ready_j  = -1;
    ld_at    = -1;
    ld_busy  = 1'b0;
    while (ready_j < 0 && j < MaxWait) begin
      @(negedge clk_i);
      j++;
      if (alu_vinsn_done_o) begin
        done_cnt++;
        done_j = j;
      end
      if (pe_req_ready_o) ready_j = j;
      if (ld_busy && ldu_gnt_o && ld_at < 0) ld_at = j;
      if (ready_j < 0) begin
        @(posedge clk_i);
        // Load raised while ALU results are on the write port
        if (with_load && j == 2) begin
          ldu_req_i <= 1'b1;
          ldu_wr_i  <= '{addr: '{vreg: req.vd, idx: eidx_t'(0)}, data: ld_data};
          ld_busy   = 1'b1;
        end else if (ld_busy && ld_at == j) begin
          ldu_req_i <= 1'b0;
          ld_busy   = 1'b0;
        end
      end
    end
    if (ready_j < 0) note_timeout("pe_req_ready_o after done");
    if (done_cnt != 1) begin
      $display("alu_vinsn_done_o pulsed %0d times for one instruction at %0t", done_cnt, $time);
      ctrl_errs++;
    end else if (done_j != vl + 3) begin
      ctrl_err("alu_vinsn_done_o cycle", vl + 3, done_j);
    end
    if (ready_j >= 0 && ready_j != vl + 4) ctrl_err("pe_req_ready_o rise cycle", vl + 4, ready_j);
    for (int e = 0; e < vl; e++) shadow[req.vd][e] = new_vals[e];
    if (with_load) begin
      if (ld_at != vl + 3) ctrl_err("ldu_gnt_o cycle", vl + 3, ld_at);
      if (ld_at >= 0) shadow[req.vd][0] = ld_data;
      if (ld_busy) begin
        @(posedge clk_i);
        ldu_req_i <= 1'b0;
      end
    end
  endtask

  task automatic report_test(input string name, input int d0, input int c0);
    $display("%s: data errors %0d, control errors %0d", name, data_errs - d0, ctrl_errs - c0);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int    d0;
    int    c0;
    int    c5;
    elem_t sc;
    seed           = 32'h8150c5d0;
    rst_ni         = 1'b0;
    pe_req_i       = '0;
    pe_req_valid_i = 1'b0;
    ldu_req_i      = 1'b0;
    ldu_wr_i       = '0;
    stu_req_i      = 1'b0;
    stu_addr_i     = '0;
    for (int v = 0; v < NrVRegs; v++) begin
      for (int e = 0; e < ElemsPerVReg; e++) shadow[v][e] = '0;
    end
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    d0 = data_errs;
    c0 = ctrl_errs;
    @(negedge clk_i);
    if (pe_req_ready_o !== 1'b1) ctrl_err("pe_req_ready_o", 1, int'(pe_req_ready_o));
    if (alu_vinsn_done_o !== 1'b0) ctrl_err("alu_vinsn_done_o", 0, int'(alu_vinsn_done_o));
    verify_all();
    report_test("test 1 reset state", d0, c0);

    d0 = data_errs;
    c0 = ctrl_errs;
    for (int v = 0; v < NrVRegs; v++) begin
      for (int e = 0; e < ElemsPerVReg; e++) begin
        load_write(vreg_t'(v), eidx_t'(e), elem_t'($random(seed)));
      end
    end
    verify_all();
    report_test("test 2 load fill", d0, c0);

    c5 = ctrl_errs;
    d0 = data_errs;
    c0 = ctrl_errs;
    for (int o = 0; o < NrOps; o++) begin
      for (int vl = 1; vl <= ElemsPerVReg; vl++) begin
        run_instr(make_req(alu_op_e'(o), vl, 1'b0, '0), 1'b0, '0);
      end
    end
    verify_all();
    report_test("test 3 vector-vector ops", d0, c0);

    d0 = data_errs;
    c0 = ctrl_errs;
    for (int o = 0; o < NrOps; o++) begin
      for (int s = 0; s < 2; s++) begin
        // Both signs of the scalar for VMIN and VMAX
        sc     = elem_t'($random(seed));
        sc[31] = (s == 1);
        run_instr(make_req(alu_op_e'(o), ((2 * o + s) % 4) + 1, 1'b1, sc), 1'b0, '0);
      end
    end
    verify_all();
    report_test("test 4 vector-scalar ops", d0, c0);
    $display("test 5 done and ready timing: control errors %0d over %0d instructions",
             ctrl_errs - c5, instrs);

    d0 = data_errs;
    c0 = ctrl_errs;
    for (int t = 0; t < ElemsPerVReg; t++) begin
      run_instr(make_req(alu_op_e'($unsigned($random(seed)) % NrOps), t + 1, 1'b0, '0),
                1'b1, elem_t'($random(seed)));
    end
    verify_all();
    report_test("test 6 load during instruction", d0, c0);

    if (exp_q.size() != 0) begin
      $display("%0d store reads never returned data", exp_q.size());
      data_errs++;
    end
    $display("reads %0d, instructions %0d, data errors %0d, control errors %0d, timeout %0d",
             reads, instrs, data_errs, ctrl_errs, timed_out);
    if (data_errs == 0 && ctrl_errs == 0 && !timed_out) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/lane_top.sv ====
//////////////////////////////
// Vector lane top level
// Decode, register file, execute and result stages
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module lane_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Main sequencer
  input  lane_pkg::pe_req_t   pe_req_i,
  input  logic                pe_req_valid_i,
  output logic                pe_req_ready_o,
  output logic                alu_vinsn_done_o,
  // Load unit
  input  logic                ldu_req_i,
  input  lane_pkg::vrf_wr_t   ldu_wr_i,
  output logic                ldu_gnt_o,
  // Store unit
  input  logic                stu_req_i,
  input  lane_pkg::vrf_addr_t stu_addr_i,
  output lane_pkg::elem_t     stu_rdata_o,
  output logic                stu_valid_o
);
  import lane_pkg::*;

  elem_op_t    elem_op;
  logic        elem_valid;
  elem_t       opa;
  elem_t       opb;
  alu_result_t alu_result;
  logic        alu_result_valid;
  logic        vrf_we;
  vrf_wr_t     vrf_wr;
  logic        vinsn_done;

  assign alu_vinsn_done_o = vinsn_done;

  lane_sequencer lane_sequencer_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pe_req_i       (pe_req_i),
    .pe_req_valid_i (pe_req_valid_i),
    .pe_req_ready_o (pe_req_ready_o),
    .vinsn_done_i   (vinsn_done),
    .elem_op_o      (elem_op),
    .elem_valid_o   (elem_valid)
  );

  vector_regfile vector_regfile_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .elem_op_i    (elem_op),
    .elem_valid_i (elem_valid),
    .opa_o        (opa),
    .opb_o        (opb),
    .we_i         (vrf_we),
    .wr_i         (vrf_wr),
    .stu_req_i    (stu_req_i),
    .stu_addr_i   (stu_addr_i),
    .stu_rdata_o  (stu_rdata_o),
    .stu_valid_o  (stu_valid_o)
  );

  lane_alu lane_alu_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .elem_op_i      (elem_op),
    .elem_valid_i   (elem_valid),
    .opa_i          (opa),
    .opb_i          (opb),
    .result_o       (alu_result),
    .result_valid_o (alu_result_valid)
  );

  lane_writeback lane_writeback_inst (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .alu_result_i       (alu_result),
    .alu_result_valid_i (alu_result_valid),
    .ldu_req_i          (ldu_req_i),
    .ldu_wr_i           (ldu_wr_i),
    .ldu_gnt_o          (ldu_gnt_o),
    .vrf_we_o           (vrf_we),
    .vrf_wr_o           (vrf_wr),
    .vinsn_done_o       (vinsn_done)
  );

endmodule

`default_nettype wire

// ==== source/lane_writeback.sv ====
//////////////////////////////
// Lane result stage
// ALU over load write arbitration
// Instruction done pulse
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module lane_writeback (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  lane_pkg::alu_result_t alu_result_i,
  input  logic                  alu_result_valid_i,
  input  logic                  ldu_req_i,
  input  lane_pkg::vrf_wr_t     ldu_wr_i,
  output logic                  ldu_gnt_o,
  output logic                  vrf_we_o,
  output lane_pkg::vrf_wr_t     vrf_wr_o,
  output logic                  vinsn_done_o
);
  import lane_pkg::*;

  vrf_wr_t alu_wr;
  logic    done_q;

  assign alu_wr.addr = alu_result_i.addr;
  assign alu_wr.data = alu_result_i.data;

  //////////////////////////////
  // Write port arbitration
  //////////////////////////////

  // ALU never stalls, the load unit takes the free cycles
  assign ldu_gnt_o = ldu_req_i & ~alu_result_valid_i;
  assign vrf_we_o  = alu_result_valid_i | ldu_gnt_o;
  assign vrf_wr_o  = alu_result_valid_i ? alu_wr : ldu_wr_i;

  // Pulse in the cycle after the last element lands
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else begin
      done_q <= alu_result_valid_i & alu_result_i.last;
    end
  end

  assign vinsn_done_o = done_q;

  // A granted load owns the write port, no ALU result shares it
  a_no_gnt_with_alu: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ldu_gnt_o |-> (vrf_we_o && vrf_wr_o == ldu_wr_i));

  // An instruction writes at most one register worth of elements back to back
  a_ldu_wait_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ldu_req_i && !ldu_gnt_o) |-> ##[1:ElemsPerVReg] ldu_gnt_o);

endmodule

`default_nettype wire

// ==== source/lane_alu.sv ====
//////////////////////////////
// Lane execute stage
// Aligns the element operation with its operands
// Integer ALU with registered result
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module lane_alu (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  lane_pkg::elem_op_t    elem_op_i,
  input  logic                  elem_valid_i,
  input  lane_pkg::elem_t       opa_i,
  input  lane_pkg::elem_t       opb_i,
  output lane_pkg::alu_result_t result_o,
  output logic                  result_valid_o
);
  import lane_pkg::*;

  elem_op_t                     op_q;
  logic                         op_valid_q;
  elem_t                        src_a;
  elem_t                        src_b;
  elem_t                        res;
  logic [$clog2(ElemWidth)-1:0] shamt;
  alu_result_t                  result_q;
  logic                         result_valid_q;

  // Operation waits one cycle for the register file read
  always_ff @(posedge clk_i) begin
    if (elem_valid_i) begin
      op_q <= elem_op_i;
    end
  end

  //////////////////////////////
  // Datapath
  //////////////////////////////

  assign src_a = opa_i;
  assign src_b = op_q.use_scalar ? op_q.scalar : opb_i;
  assign shamt = src_b[$clog2(ElemWidth)-1:0];

  always_comb begin
    case (op_q.op)
      VADD:    res = src_a + src_b;
      VSUB:    res = src_a - src_b;
      VAND:    res = src_a & src_b;
      VOR:     res = src_a | src_b;
      VXOR:    res = src_a ^ src_b;
      VSLL:    res = src_a << shamt;
      VSRL:    res = src_a >> shamt;
      VSRA:    res = elem_t'($signed(src_a) >>> shamt);
      VMIN:    res = ($signed(src_a) < $signed(src_b)) ? src_a : src_b;
      VMAX:    res = ($signed(src_a) > $signed(src_b)) ? src_a : src_b;
      default: res = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (op_valid_q) begin
      result_q.addr.vreg <= op_q.vd;
      result_q.addr.idx  <= op_q.idx;
      result_q.data      <= res;
      result_q.last      <= op_q.last;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_valid_q     <= 1'b0;
      result_valid_q <= 1'b0;
    end else begin
      op_valid_q     <= elem_valid_i;
      result_valid_q <= op_valid_q;
    end
  end

  assign result_o       = result_q;
  assign result_valid_o = result_valid_q;

endmodule

`default_nettype wire

// ==== source/vector_regfile.sv ====
//////////////////////////////
// Lane slice of the vector register file
// Two registered operand reads
// Registered store read and one write port
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module vector_regfile (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  lane_pkg::elem_op_t  elem_op_i,
  input  logic                elem_valid_i,
  output lane_pkg::elem_t     opa_o,
  output lane_pkg::elem_t     opb_o,
  input  logic                we_i,
  input  lane_pkg::vrf_wr_t   wr_i,
  input  logic                stu_req_i,
  input  lane_pkg::vrf_addr_t stu_addr_i,
  output lane_pkg::elem_t     stu_rdata_o,
  output logic                stu_valid_o
);
  import lane_pkg::*;

  elem_t vrf_q [NrVRegs][ElemsPerVReg];
  elem_t opa_q;
  elem_t opb_q;
  elem_t stu_rdata_q;
  logic  stu_valid_q;

  //////////////////////////////
  // Storage
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned r = 0; r < NrVRegs; r++) begin
        for (int unsigned e = 0; e < ElemsPerVReg; e++) begin
          vrf_q[r][e] <= '0;
        end
      end
    end else if (we_i) begin
      vrf_q[wr_i.addr.vreg][wr_i.addr.idx] <= wr_i.data;
    end
  end

  //////////////////////////////
  // Read ports
  //////////////////////////////

  // Operand A is the vs2 element, operand B the vs1 element
  always_ff @(posedge clk_i) begin
    if (elem_valid_i) begin
      opa_q <= vrf_q[elem_op_i.vs2][elem_op_i.idx];
      opb_q <= vrf_q[elem_op_i.vs1][elem_op_i.idx];
    end
  end

  // Store port sees the value before a same-cycle write
  always_ff @(posedge clk_i) begin
    if (stu_req_i) begin
      stu_rdata_q <= vrf_q[stu_addr_i.vreg][stu_addr_i.idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stu_valid_q <= 1'b0;
    end else begin
      stu_valid_q <= stu_req_i;
    end
  end

  assign opa_o       = opa_q;
  assign opb_o       = opb_q;
  assign stu_rdata_o = stu_rdata_q;
  assign stu_valid_o = stu_valid_q;

endmodule

`default_nettype wire

// ==== source/lane_sequencer.sv ====
//////////////////////////////
// Lane decode stage
// Accepts one instruction at a time and issues
// one element operation per cycle
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module lane_sequencer (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  lane_pkg::pe_req_t  pe_req_i,
  input  logic               pe_req_valid_i,
  output logic               pe_req_ready_o,
  input  logic               vinsn_done_i,
  output lane_pkg::elem_op_t elem_op_o,
  output logic               elem_valid_o
);
  import lane_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_DONE
  } state_e;

  state_e   state_q;
  state_e   state_d;
  pe_req_t  req_q;
  eidx_t    idx_q;
  logic     last_elem;
  elem_op_t elem_op_d;
  elem_op_t elem_op_q;
  logic     elem_valid_q;

  assign pe_req_ready_o = (state_q == IDLE);
  assign last_elem      = (vl_t'(idx_q) + vl_t'(1)) == req_q.vl;

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:      if (pe_req_valid_i) state_d = ISSUE;
      ISSUE:     if (last_elem) state_d = WAIT_DONE;
      // Writeback signals the end of the last element
      WAIT_DONE: if (vinsn_done_i) state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      idx_q        <= '0;
      elem_valid_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      elem_valid_q <= (state_q == ISSUE);
      if (state_q == ISSUE) begin
        idx_q <= idx_q + eidx_t'(1);
      end else begin
        idx_q <= '0;
      end
    end
  end

  //////////////////////////////
  // Element operation
  //////////////////////////////

  always_comb begin
    elem_op_d.op         = req_q.op;
    elem_op_d.vd         = req_q.vd;
    elem_op_d.vs1        = req_q.vs1;
    elem_op_d.vs2        = req_q.vs2;
    elem_op_d.idx        = idx_q;
    elem_op_d.use_scalar = req_q.use_scalar;
    elem_op_d.scalar     = req_q.scalar;
    elem_op_d.last       = last_elem;
  end

  always_ff @(posedge clk_i) begin
    if (pe_req_valid_i && pe_req_ready_o) begin
      req_q <= pe_req_i;
    end
    if (state_q == ISSUE) begin
      elem_op_q <= elem_op_d;
    end
  end

  assign elem_op_o    = elem_op_q;
  assign elem_valid_o = elem_valid_q;

  // Elements leave the issue register only while an instruction is open
  a_issue_in_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
    elem_valid_o |-> (state_q != IDLE));

  a_vl_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pe_req_valid_i && pe_req_ready_o) |->
      (pe_req_i.vl >= 1 && pe_req_i.vl <= ElemsPerVReg));

  // Done from writeback only while an instruction is open
  a_done_when_waiting: assert property (@(posedge clk_i) disable iff (!rst_ni)
    vinsn_done_i |-> (state_q == WAIT_DONE));

endmodule

`default_nettype wire

// ==== source/lane_pkg.sv ====
//////////////////////////////
// Shared definitions of the vector lane
// Element and register file widths
// ALU opcodes
// Request, element operation, write and result structs
//////////////////////////////

`default_nettype none

package lane_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  localparam int unsigned ElemWidth    = 32;
  localparam int unsigned NrVRegs      = 8;
  localparam int unsigned ElemsPerVReg = 4;

  // Plain vector types
  typedef logic [ElemWidth-1:0]              elem_t;
  typedef logic [$clog2(NrVRegs)-1:0]        vreg_t;
  typedef logic [$clog2(ElemsPerVReg)-1:0]   eidx_t;
  // One bit wider than the index so that a full register fits
  typedef logic [$clog2(ElemsPerVReg):0]     vl_t;

  // Integer ALU operations, VMIN and VMAX compare signed
  typedef enum logic [3:0] {
    VADD,
    VSUB,
    VAND,
    VOR,
    VXOR,
    VSLL,
    VSRL,
    VSRA,
    VMIN,
    VMAX
  } alu_op_e;

  //////////////////////////////
  // Structs
  //////////////////////////////

  // Instruction from the main sequencer
  typedef struct packed {
    alu_op_e op;
    vreg_t   vd;
    vreg_t   vs1;
    vreg_t   vs2;
    vl_t     vl;
    logic    use_scalar;
    elem_t   scalar;
  } pe_req_t;

  // One element of an instruction
  typedef struct packed {
    alu_op_e op;
    vreg_t   vd;
    vreg_t   vs1;
    vreg_t   vs2;
    eidx_t   idx;
    logic    use_scalar;
    elem_t   scalar;
    logic    last;
  } elem_op_t;

  typedef struct packed {
    vreg_t vreg;
    eidx_t idx;
  } vrf_addr_t;

  typedef struct packed {
    vrf_addr_t addr;
    elem_t     data;
  } vrf_wr_t;

  typedef struct packed {
    vrf_addr_t addr;
    elem_t     data;
    logic      last;
  } alu_result_t;

endpackage

`default_nettype wire
